//--- hdl/alu_exec.sv
`timescale 1ns/1ps

module alu_exec (
    input  logic                clk,
    input  logic                i_rst_n,
    opr_bus.sink                opr,
    output mips_pkg::word_t     o_alu_fwd_data,
    output logic                o_wb_valid,
    input  logic                i_wb_ready,
    output logic                o_wb_en,
    output mips_pkg::reg_addr_t o_wb_reg,
    output mips_pkg::word_t     o_wb_data,
    output logic                o_rf_wr_en
);
    import mips_pkg::*;

    word_t alu_result;
    logic  take;

    always_comb begin
        case (opr.alu_op)
            ALU_ADD:  alu_result = opr.op_a + opr.op_b;     // no overflow trap for the u forms
            ALU_SUB:  alu_result = opr.op_a - opr.op_b;
            ALU_AND:  alu_result = opr.op_a & opr.op_b;
            ALU_OR:   alu_result = opr.op_a | opr.op_b;
            ALU_XOR:  alu_result = opr.op_a ^ opr.op_b;
            ALU_NOR:  alu_result = ~(opr.op_a | opr.op_b);
            ALU_SLT:  alu_result = {31'd0, $signed(opr.op_a) < $signed(opr.op_b)};
            ALU_SLTU: alu_result = {31'd0, opr.op_a < opr.op_b};
            // shifts work on the rt value by the shamt field
            ALU_SLL:  alu_result = opr.op_b << opr.shamt;
            ALU_SRL:  alu_result = opr.op_b >> opr.shamt;
            ALU_SRA:  alu_result = word_t'($signed(opr.op_b) >>> opr.shamt);
            ALU_LUI:  alu_result = {opr.op_b[15:0], 16'd0};
            default:  alu_result = '0;                       // nothing to write gives zero data
        endcase
    end

    // operand stage picks this up for a dependent instruction right behind
    assign o_alu_fwd_data = alu_result;

    assign opr.ready = !o_wb_valid || i_wb_ready;
    assign take      = opr.valid && opr.ready;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wb_valid <= 1'b0;
            o_wb_en    <= 1'b0;
        end else if (take) begin
            o_wb_valid <= 1'b1;
            o_wb_en    <= opr.write_en;
        end else if (i_wb_ready) begin
            o_wb_valid <= 1'b0;
            o_wb_en    <= 1'b0;
        end
    end

    // the record stays put until the consumer takes it
    always_ff @(posedge clk) begin
        if (take) begin
            o_wb_reg  <= opr.dest;
            o_wb_data <= alu_result;
        end
    end

    // register file commits on the same edge as the output transfer
    assign o_rf_wr_en = o_wb_valid && i_wb_ready && o_wb_en;

endmodule

//--- hdl/ir_decode.sv
`timescale 1ns/1ps

module ir_decode (
    input  logic            clk,
    input  logic            i_rst_n,
    input  logic            i_instr_valid,
    output logic            o_instr_ready,
    input  mips_pkg::word_t i_instr,
    dec_bus.source          dec
);
    import mips_pkg::*;

    opcode_t     opcode;
    funct_t      funct;
    reg_addr_t   rd;
    reg_addr_t   rt;
    instr_kind_t kind_d;
    alu_op_t     op_d;       // operation before the write enable is known
    reg_addr_t   dest_d;
    word_t       imm_d;
    logic        use_imm_d;
    logic        we_d;
    logic        take;

    assign opcode = opcode_t'(i_instr[31:26]);
    assign funct  = i_instr[5:0];
    assign rd     = i_instr[15:11];
    assign rt     = i_instr[20:16];

    always_comb begin
        op_d      = ALU_NONE;
        dest_d    = '0;
        use_imm_d = 1'b0;
        imm_d     = {{16{i_instr[15]}}, i_instr[15:0]}; // sign extension unless told otherwise
        if (opcode == OP_SPECIAL) begin
            kind_d = KIND_R;
            dest_d = rd;
            case (funct)
                F_ADDU:  op_d = ALU_ADD;
                F_SUBU:  op_d = ALU_SUB;
                F_AND:   op_d = ALU_AND;
                F_OR:    op_d = ALU_OR;
                F_XOR:   op_d = ALU_XOR;
                F_NOR:   op_d = ALU_NOR;
                F_SLT:   op_d = ALU_SLT;
                F_SLTU:  op_d = ALU_SLTU;
                F_SLL:   op_d = ALU_SLL;
                F_SRL:   op_d = ALU_SRL;
                F_SRA:   op_d = ALU_SRA;
                default: op_d = ALU_NONE;   // jr and jalr leave the registers alone here
            endcase
        end else if (opcode == OP_J || opcode == OP_JAL) begin
            kind_d = KIND_J;                // no registers and no immediate in use
            imm_d  = '0;
        end else begin
            kind_d    = KIND_I;
            dest_d    = rt;                 // i type writes back into rt
            use_imm_d = 1'b1;
            case (opcode)
                OP_ADDIU: op_d = ALU_ADD;
                OP_SLTI:  op_d = ALU_SLT;
                OP_SLTIU: op_d = ALU_SLTU;  // sign extended and then compared unsigned
                OP_ANDI:  op_d = ALU_AND;
                OP_ORI:   op_d = ALU_OR;
                OP_XORI:  op_d = ALU_XOR;
                OP_LUI:   op_d = ALU_LUI;
                default:  op_d = ALU_NONE;  // branches, loads and stores
            endcase
            // the logical immediates are zero extended
            if (opcode == OP_ANDI || opcode == OP_ORI || opcode == OP_XORI || opcode == OP_LUI) begin
                imm_d = {16'd0, i_instr[15:0]};
            end
        end
    end

    // a write to register zero is dropped here so the record carries zero data
    assign we_d = (op_d != ALU_NONE) && (dest_d != '0);

    // the output register is free when empty or being drained this cycle
    assign o_instr_ready = !dec.valid || dec.ready;
    assign take          = i_instr_valid && o_instr_ready;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            dec.valid <= 1'b0;
        end else if (take) begin
            dec.valid <= 1'b1;
        end else if (dec.ready) begin
            dec.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            dec.kind     <= kind_d;
            dec.alu_op   <= we_d ? op_d : ALU_NONE;
            dec.rs       <= i_instr[25:21];
            dec.rt       <= rt;
            dec.dest     <= dest_d;
            dec.shamt    <= i_instr[10:6];
            dec.imm      <= imm_d;
            dec.use_imm  <= use_imm_d;
            dec.write_en <= we_d;
        end
    end

endmodule

//--- hdl/mips_core.sv
`timescale 1ns/1ps

module mips_core (
    input  logic                clk,
    input  logic                i_rst_n,
    input  logic                i_instr_valid,
    output logic                o_instr_ready,
    input  mips_pkg::word_t     i_instr,
    output logic                o_wb_valid,
    input  logic                i_wb_ready,
    output logic                o_wb_en,
    output mips_pkg::reg_addr_t o_wb_reg,
    output mips_pkg::word_t     o_wb_data
);
    import mips_pkg::*;

    word_t alu_fwd_data;  // combinational execute result
    logic  rf_wr_en;      // writeback record accepted with its enable set

    dec_bus dec_bus_i ();
    opr_bus opr_bus_i ();

    ir_decode ir_decode_i (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_instr_valid (i_instr_valid),
        .o_instr_ready (o_instr_ready),
        .i_instr       (i_instr),
        .dec           (dec_bus_i)
    );

    // the writeback outputs double as the register file write port
    operand_read operand_read_i (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .dec            (dec_bus_i),
        .opr            (opr_bus_i),
        .i_exe_valid    (o_wb_valid),
        .i_exe_write    (o_wb_en),
        .i_exe_reg      (o_wb_reg),
        .i_exe_data     (o_wb_data),
        .i_rf_wr_en     (rf_wr_en),
        .i_alu_fwd_data (alu_fwd_data)
    );

    alu_exec alu_exec_i (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .opr            (opr_bus_i),
        .o_alu_fwd_data (alu_fwd_data),
        .o_wb_valid     (o_wb_valid),
        .i_wb_ready     (i_wb_ready),
        .o_wb_en        (o_wb_en),
        .o_wb_reg       (o_wb_reg),
        .o_wb_data      (o_wb_data),
        .o_rf_wr_en     (rf_wr_en)
    );

endmodule

//--- hdl/mips_pkg.sv
package mips_pkg;

    typedef logic [31:0] word_t;      // data and instruction words
    typedef logic [4:0]  reg_addr_t;  // one of the 32 general registers
    typedef logic [4:0]  shamt_t;     // shift amount field of an r type word
    typedef logic [5:0]  funct_t;     // function field of an r type word

    // fixed by the 5 bit register fields of the instruction format
    localparam int NUM_REGS = 32;

    // primary opcodes in bits 31:26
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,  // r type, the function field picks the operation
        OP_REGIMM  = 6'b000001,  // bltz, bgez and their linking forms
        OP_J       = 6'b000010,
        OP_JAL     = 6'b000011,
        OP_BEQ     = 6'b000100,
        OP_BNE     = 6'b000101,
        OP_BLEZ    = 6'b000110,
        OP_BGTZ    = 6'b000111,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_SLTIU   = 6'b001011,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111,
        OP_LB      = 6'b100000,
        OP_LH      = 6'b100001,
        OP_LWL     = 6'b100010,
        OP_LW      = 6'b100011,
        OP_LBU     = 6'b100100,
        OP_LHU     = 6'b100101,
        OP_LWR     = 6'b100110,
        OP_SB      = 6'b101000,
        OP_SH      = 6'b101001,
        OP_SW      = 6'b101011
    } opcode_t;

    // function codes in bits 5:0 of an r type word
    typedef enum logic [5:0] {
        F_SLL  = 6'b000000,
        F_SRL  = 6'b000010,
        F_SRA  = 6'b000011,
        F_JR   = 6'b001000,
        F_JALR = 6'b001001,
        F_ADDU = 6'b100001,
        F_SUBU = 6'b100011,
        F_AND  = 6'b100100,
        F_OR   = 6'b100101,
        F_XOR  = 6'b100110,
        F_NOR  = 6'b100111,
        F_SLT  = 6'b101010,
        F_SLTU = 6'b101011
    } funct_code_t;

    // what the execute stage does with op_a and op_b
    typedef enum logic [3:0] {
        ALU_NONE, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_t;

    typedef enum logic [1:0] {KIND_R, KIND_I, KIND_J} instr_kind_t;

endpackage

//--- hdl/operand_read.sv
`timescale 1ns/1ps

module operand_read (
    input  logic                clk,
    input  logic                i_rst_n,
    dec_bus.sink                dec,
    opr_bus.source              opr,
    input  logic                i_exe_valid,     // writeback record is waiting
    input  logic                i_exe_write,
    input  mips_pkg::reg_addr_t i_exe_reg,
    input  mips_pkg::word_t     i_exe_data,
    input  logic                i_rf_wr_en,      // record leaves this cycle and writes
    input  mips_pkg::word_t     i_alu_fwd_data   // result of the instruction in execute
);
    import mips_pkg::*;

    reg_addr_t src_a;
    reg_addr_t src_b;
    word_t     rf_data_a;
    word_t     rf_data_b;
    word_t     val_a;
    word_t     val_b;
    logic      alu_hit_a, alu_hit_b;
    logic      exe_hit_a, exe_hit_b;
    logic      take;

    // j type reads nothing and i type only reads rs, so no false forwards happen
    assign src_a = (dec.kind == KIND_J) ? '0 : dec.rs;
    assign src_b = (dec.kind == KIND_R) ? dec.rt : '0;

    reg_file reg_file_i (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_rd_addr_a (src_a),
        .i_rd_addr_b (src_b),
        .o_rd_data_a (rf_data_a),
        .o_rd_data_b (rf_data_b),
        .i_wr_en     (i_rf_wr_en),
        .i_wr_addr   (i_exe_reg),
        .i_wr_data   (i_exe_data)
    );

    // write_en is never set for register zero, so zero never matches a hit
    assign alu_hit_a = opr.valid && opr.write_en && (opr.dest == src_a);
    assign alu_hit_b = opr.valid && opr.write_en && (opr.dest == src_b);
    assign exe_hit_a = i_exe_valid && i_exe_write && (i_exe_reg == src_a);
    assign exe_hit_b = i_exe_valid && i_exe_write && (i_exe_reg == src_b);

    // the younger producer wins over the waiting record, which wins over the array
    assign val_a = alu_hit_a ? i_alu_fwd_data : exe_hit_a ? i_exe_data : rf_data_a;
    assign val_b = alu_hit_b ? i_alu_fwd_data : exe_hit_b ? i_exe_data : rf_data_b;

    assign dec.ready = !opr.valid || opr.ready;
    assign take      = dec.valid && dec.ready;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            opr.valid <= 1'b0;
        end else if (take) begin
            opr.valid <= 1'b1;
        end else if (opr.ready) begin
            opr.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            opr.alu_op   <= dec.alu_op;
            opr.op_a     <= val_a;
            opr.op_b     <= dec.use_imm ? dec.imm : val_b;  // lui takes its immediate here too
            opr.shamt    <= dec.shamt;
            opr.dest     <= dec.dest;
            opr.write_en <= dec.write_en;
        end
    end

endmodule

//--- hdl/pipe_if.sv
`timescale 1ns/1ps

// decode to operand stage, one decoded instruction per transfer
interface dec_bus;
    import mips_pkg::*;

    logic        valid;     // payload below is meaningful
    logic        ready;     // operand stage can take it this cycle
    instr_kind_t kind;
    alu_op_t     alu_op;
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   dest;      // rd for r type and rt for i type
    shamt_t      shamt;
    word_t       imm;       // already sign or zero extended
    logic        use_imm;   // op_b comes from imm and not from rt
    logic        write_en;

    modport source (
        output valid, kind, alu_op, rs, rt, dest, shamt, imm, use_imm, write_en,
        input  ready
    );

    modport sink (
        input  valid, kind, alu_op, rs, rt, dest, shamt, imm, use_imm, write_en,
        output ready
    );
endinterface

// operand to execute stage, the operands are resolved values here
interface opr_bus;
    import mips_pkg::*;

    logic      valid;
    logic      ready;
    alu_op_t   alu_op;
    word_t     op_a;
    word_t     op_b;
    shamt_t    shamt;
    reg_addr_t dest;
    logic      write_en;

    modport source (output valid, alu_op, op_a, op_b, shamt, dest, write_en, input ready);
    modport sink   (input valid, alu_op, op_a, op_b, shamt, dest, write_en, output ready);
endinterface

//--- hdl/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                clk,
    input  logic                i_rst_n,
    input  mips_pkg::reg_addr_t i_rd_addr_a,
    input  mips_pkg::reg_addr_t i_rd_addr_b,
    output mips_pkg::word_t     o_rd_data_a,
    output mips_pkg::word_t     o_rd_data_b,
    input  logic                i_wr_en,
    input  mips_pkg::reg_addr_t i_wr_addr,
    input  mips_pkg::word_t     i_wr_data
);
    import mips_pkg::*;

    word_t regs [NUM_REGS];

    // every register starts at zero, and entry zero is never written afterwards
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en && i_wr_addr != '0) begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    // reads see the array as it stands, so a write in this cycle is not visible yet
    assign o_rd_data_a = regs[i_rd_addr_a];
    assign o_rd_data_b = regs[i_rd_addr_b];

endmodule

//--- project.f
hdl/mips_pkg.sv
hdl/pipe_if.sv
hdl/reg_file.sv
hdl/ir_decode.sv
hdl/operand_read.sv
hdl/alu_exec.sv
hdl/mips_core.sv
testbench/tb_mips_core.sv

//--- run.sh
#!/usr/bin/env bash
# builds the testbench with verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f project.f --top-module tb_mips_core \
    && ./obj_dir/Vtb_mips_core | tee /dev/stderr | grep -x "test passed" > /dev/null \
    && echo "simulation run ok" \
    || { echo "simulation run not ok" >&2; exit 1; }

//--- testbench/tb_mips_core.sv
`timescale 1ns/1ps

module tb_mips_core;
    import mips_pkg::*;

    localparam int WAIT_LIMIT = 200;  // cycles that any single wait may take
    localparam int LATENCY    = 3;    // input transfer to output transfer with ready held high

    logic      clk = 1'b0;
    logic      i_rst_n;
    logic      i_instr_valid;
    logic      o_instr_ready;
    word_t     i_instr;
    logic      o_wb_valid;
    logic      i_wb_ready;
    logic      o_wb_en;
    reg_addr_t o_wb_reg;
    word_t     o_wb_data;

    // one entry per instruction, expected values worked out by hand
    string     tbl_name [$];
    word_t     tbl_instr [$];
    logic      tbl_en [$];
    reg_addr_t tbl_reg [$];
    word_t     tbl_data [$];
    int        accept_edge [$];      // edge index at which each instruction was taken
    int        n_timed;              // entries before this index run with ready held high
    int        cycle = 0;
    int        rec_count = 0;        // writeback records seen so far
    int        mismatches = 0;
    int        order_errs = 0;
    int        wait_errs = 0;
    int        seed = 32'hcf56_7866;
    logic      bp_mode = 1'b0;       // random back-pressure on the output
    logic      stuck = 1'b0;

    mips_core mips_core_i (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_instr_valid (i_instr_valid),
        .o_instr_ready (o_instr_ready),
        .i_instr       (i_instr),
        .o_wb_valid    (o_wb_valid),
        .i_wb_ready    (i_wb_ready),
        .o_wb_en       (o_wb_en),
        .o_wb_reg      (o_wb_reg),
        .o_wb_data     (o_wb_data)
    );

    always #20 clk = ~clk;
    always @(posedge clk) cycle <= cycle + 1;  // value after edge k reads as k

    function automatic word_t encode_r(funct_code_t f, reg_addr_t rs, reg_addr_t rt,
                                       reg_addr_t rd, shamt_t sh);
        return {OP_SPECIAL, rs, rt, rd, sh, f};
    endfunction

    function automatic word_t encode_i(opcode_t op, reg_addr_t rs, reg_addr_t rt,
                                       logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t encode_j(opcode_t op, logic [25:0] target);
        return {op, target};
    endfunction

    task automatic add_entry(string nm, word_t instr, logic en, reg_addr_t rd, word_t data);
        tbl_name.push_back(nm);
        tbl_instr.push_back(instr);
        tbl_en.push_back(en);
        tbl_reg.push_back(rd);
        tbl_data.push_back(data);
    endtask

    task automatic build_table();
        // r1 = 0x80000005 and r2 = 7 feed the r type checks
        add_entry("lui_r1", encode_i(OP_LUI, 5'd0, 5'd1, 16'h8000), 1'b1, 5'd1, 32'h8000_0000);
        add_entry("ori_r1", encode_i(OP_ORI, 5'd1, 5'd1, 16'h0005), 1'b1, 5'd1, 32'h8000_0005);
        add_entry("ori_r2", encode_i(OP_ORI, 5'd0, 5'd2, 16'h0007), 1'b1, 5'd2, 32'h0000_0007);
        add_entry("addu", encode_r(F_ADDU, 5'd1, 5'd2, 5'd3, 5'd0), 1'b1, 5'd3, 32'h8000_000c);
        add_entry("subu", encode_r(F_SUBU, 5'd2, 5'd1, 5'd4, 5'd0), 1'b1, 5'd4, 32'h8000_0002);
        add_entry("and", encode_r(F_AND, 5'd1, 5'd2, 5'd5, 5'd0), 1'b1, 5'd5, 32'h0000_0005);
        add_entry("or", encode_r(F_OR, 5'd1, 5'd2, 5'd6, 5'd0), 1'b1, 5'd6, 32'h8000_0007);
        add_entry("xor", encode_r(F_XOR, 5'd1, 5'd2, 5'd7, 5'd0), 1'b1, 5'd7, 32'h8000_0002);
        add_entry("nor", encode_r(F_NOR, 5'd1, 5'd2, 5'd8, 5'd0), 1'b1, 5'd8, 32'h7fff_fff8);
        add_entry("slt_neg", encode_r(F_SLT, 5'd1, 5'd2, 5'd9, 5'd0), 1'b1, 5'd9, 32'd1);
        add_entry("sltu_neg", encode_r(F_SLTU, 5'd1, 5'd2, 5'd10, 5'd0), 1'b1, 5'd10, 32'd0);
        add_entry("sll", encode_r(F_SLL, 5'd0, 5'd2, 5'd11, 5'd4), 1'b1, 5'd11, 32'h0000_0070);
        add_entry("srl", encode_r(F_SRL, 5'd0, 5'd1, 5'd12, 5'd4), 1'b1, 5'd12, 32'h0800_0000);
        add_entry("sra", encode_r(F_SRA, 5'd0, 5'd1, 5'd13, 5'd4), 1'b1, 5'd13, 32'hf800_0000);
        // immediates, 0xffff and 0x8000 show the extension
        add_entry("addiu", encode_i(OP_ADDIU, 5'd2, 5'd14, 16'hfffe), 1'b1, 5'd14, 32'd5);
        add_entry("slti_lt", encode_i(OP_SLTI, 5'd1, 5'd15, 16'hffff), 1'b1, 5'd15, 32'd1);
        add_entry("slti_ge", encode_i(OP_SLTI, 5'd2, 5'd16, 16'h8000), 1'b1, 5'd16, 32'd0);
        add_entry("andi", encode_i(OP_ANDI, 5'd1, 5'd17, 16'hffff), 1'b1, 5'd17, 32'd5);
        add_entry("ori", encode_i(OP_ORI, 5'd0, 5'd18, 16'h8001), 1'b1, 5'd18, 32'h0000_8001);
        add_entry("xori", encode_i(OP_XORI, 5'd1, 5'd19, 16'hffff), 1'b1, 5'd19, 32'h8000_fffa);
        add_entry("lui", encode_i(OP_LUI, 5'd0, 5'd20, 16'h1234), 1'b1, 5'd20, 32'h1234_0000);
        add_entry("sltiu", encode_i(OP_SLTIU, 5'd2, 5'd21, 16'hffff), 1'b1, 5'd21, 32'd1);
        // forwarding at distances one, two and three
        add_entry("fwd_base", encode_i(OP_ADDIU, 5'd0, 5'd22, 16'h0010), 1'b1, 5'd22, 32'd16);
        add_entry("fwd_d1", encode_r(F_ADDU, 5'd22, 5'd22, 5'd23, 5'd0), 1'b1, 5'd23, 32'd32);
        add_entry("fwd_fill", encode_i(OP_ADDIU, 5'd0, 5'd24, 16'h0003), 1'b1, 5'd24, 32'd3);
        add_entry("fwd_d2_d3", encode_r(F_ADDU, 5'd23, 5'd22, 5'd25, 5'd0), 1'b1, 5'd25, 32'd48);
        add_entry("fwd_d1_d2", encode_r(F_SUBU, 5'd25, 5'd24, 5'd26, 5'd0), 1'b1, 5'd26, 32'd45);
        add_entry("fwd_d3", encode_r(F_ADDU, 5'd24, 5'd23, 5'd27, 5'd0), 1'b1, 5'd27, 32'd35);
        // nothing written, so enable low and data zero
        add_entry("jr", encode_r(F_JR, 5'd1, 5'd0, 5'd0, 5'd0), 1'b0, 5'd0, 32'd0);
        add_entry("beq", encode_i(OP_BEQ, 5'd1, 5'd2, 16'h0004), 1'b0, 5'd0, 32'd0);
        add_entry("j", encode_j(OP_J, 26'h000_0100), 1'b0, 5'd0, 32'd0);
        add_entry("sw", encode_i(OP_SW, 5'd0, 5'd3, 16'h0008), 1'b0, 5'd0, 32'd0);
        add_entry("addu_r0", encode_r(F_ADDU, 5'd1, 5'd2, 5'd0, 5'd0), 1'b0, 5'd0, 32'd0);
        add_entry("read_r0", encode_r(F_ADDU, 5'd0, 5'd1, 5'd28, 5'd0), 1'b1, 5'd28, 32'h8000_0005);
        n_timed = tbl_instr.size();
        // dependent chain under random back-pressure
        add_entry("bp_set", encode_i(OP_ADDIU, 5'd0, 5'd1, 16'h0001), 1'b1, 5'd1, 32'd1);
        add_entry("bp_dbl1", encode_r(F_ADDU, 5'd1, 5'd1, 5'd1, 5'd0), 1'b1, 5'd1, 32'd2);
        add_entry("bp_dbl2", encode_r(F_ADDU, 5'd1, 5'd1, 5'd1, 5'd0), 1'b1, 5'd1, 32'd4);
        add_entry("bp_sll", encode_r(F_SLL, 5'd0, 5'd1, 5'd2, 5'd3), 1'b1, 5'd2, 32'd32);
        add_entry("bp_subu", encode_r(F_SUBU, 5'd2, 5'd1, 5'd3, 5'd0), 1'b1, 5'd3, 32'd28);
        add_entry("bp_sw", encode_i(OP_SW, 5'd0, 5'd3, 16'h0000), 1'b0, 5'd0, 32'd0);
        add_entry("bp_xori", encode_i(OP_XORI, 5'd3, 5'd4, 16'h00ff), 1'b1, 5'd4, 32'h0000_00e3);
        add_entry("bp_nor", encode_r(F_NOR, 5'd0, 5'd0, 5'd6, 5'd0), 1'b1, 5'd6, 32'hffff_ffff);
        add_entry("bp_sra", encode_r(F_SRA, 5'd0, 5'd6, 5'd7, 5'd8), 1'b1, 5'd7, 32'hffff_ffff);
        add_entry("bp_wrap", encode_r(F_ADDU, 5'd6, 5'd1, 5'd9, 5'd0), 1'b1, 5'd9, 32'd3);
        add_entry("bp_lui", encode_i(OP_LUI, 5'd0, 5'd10, 16'habcd), 1'b1, 5'd10, 32'habcd_0000);
        add_entry("bp_or", encode_r(F_OR, 5'd10, 5'd9, 5'd11, 5'd0), 1'b1, 5'd11, 32'habcd_0003);
    endtask

    // called at 2 ns after an edge and returns at the same point of a later cycle
    task automatic send_instr(input int idx);
        int   waited;
        logic taken;
        waited        = 0;
        taken         = 1'b0;
        i_instr_valid = 1'b1;
        i_instr       = tbl_instr[idx];
        while (!taken && waited < WAIT_LIMIT) begin
            @(negedge clk);
            taken = o_instr_ready;  // transfer happens on the coming edge
            @(posedge clk);
            #2;
            waited++;
        end
        if (taken) begin
            accept_edge.push_back(cycle);
        end else begin
            $display("ERROR: instruction %s was not accepted within %0d cycles",
                     tbl_name[idx], WAIT_LIMIT);
            wait_errs++;
            stuck = 1'b1;
        end
    endtask

    task automatic wait_records(input int target);
        int waited;
        waited = 0;
        while (rec_count < target && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (rec_count < target) begin
            $display("ERROR: only %0d of %0d writeback records arrived in time", rec_count, target);
            wait_errs++;
        end
    endtask

    task automatic check_record(input int idx);
        string nm;
        nm = tbl_name[idx];
        assert (o_wb_en == tbl_en[idx]) else begin
            $display("MISMATCH %s: o_wb_en expected %0b actual %0b", nm, tbl_en[idx], o_wb_en);
            mismatches++;
        end
        assert (o_wb_data == tbl_data[idx]) else begin
            $display("MISMATCH %s: o_wb_data expected %h actual %h", nm, tbl_data[idx], o_wb_data);
            mismatches++;
        end
        if (tbl_en[idx]) begin
            assert (o_wb_reg == tbl_reg[idx]) else begin
                $display("MISMATCH %s: o_wb_reg expected %0d actual %0d", nm, tbl_reg[idx], o_wb_reg);
                mismatches++;
            end
        end
        if (idx < n_timed) begin
            // the record leaves on the next edge, so that edge is cycle + 1
            assert (cycle + 1 - accept_edge[idx] == LATENCY) else begin
                $display("MISMATCH %s: latency expected %0d actual %0d", nm, LATENCY,
                         cycle + 1 - accept_edge[idx]);
                mismatches++;
            end
        end
    endtask

    // output ready, random while bp_mode is set
    initial begin
        int rnd;
        i_wb_ready = 1'b1;
        forever begin
            @(posedge clk);
            #2;
            rnd        = $random(seed);
            i_wb_ready = bp_mode ? rnd[0] : 1'b1;
        end
    end

    // outputs are stable at the falling edge, each accepted record is checked in order
    always @(negedge clk) begin
        if (i_rst_n && o_wb_valid && i_wb_ready) begin
            if (rec_count >= tbl_instr.size()) begin
                $display("ERROR: extra writeback record for r%0d after the last entry", o_wb_reg);
                order_errs++;
            end else begin
                check_record(rec_count);
                rec_count++;
            end
        end
    end

    initial begin
        i_rst_n       = 1'b0;
        i_instr_valid = 1'b0;
        i_instr       = '0;
        build_table();
        repeat (4) @(posedge clk);
        #2;
        i_rst_n = 1'b1;
        for (int i = 0; i < n_timed && !stuck; i++) begin
            send_instr(i);
        end
        i_instr_valid = 1'b0;
        wait_records(n_timed);
        @(negedge clk);
        bp_mode = 1'b1;
        @(posedge clk);
        #2;
        for (int i = n_timed; i < tbl_instr.size() && !stuck; i++) begin
            send_instr(i);
        end
        i_instr_valid = 1'b0;
        wait_records(tbl_instr.size());
        @(negedge clk);
        bp_mode = 1'b0;
        repeat (5) @(posedge clk);  // room for a duplicated record to show up
        $display("errors: %0d mismatches, %0d ordering, %0d timeouts",
                 mismatches, order_errs, wait_errs);
        if (mismatches + order_errs + wait_errs == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
